// File: filelist.f
+incdir+source
source/zx_display_pkg.sv
source/display_if.sv
source/glyph_fetch.sv
source/pixel_shifter.sv
source/color_mixer.sv
source/zx_display.sv
test/tb_zx_display.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_zx_display -o tb_zx_display

output=$(./obj_dir/tb_zx_display)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
	exit 0
fi
exit 1

// File: source/color_mixer.sv
`timescale 1ns/1ns

module color_mixer (
	input logic clk_sys,
	input logic reset,
	input logic invert_video,
	input logic black_border,
	input logic chroma_en,
	input zx_display_pkg::igrb_t chroma_border,
	pixel_if.mix_side pixels,
	output logic pix_valid,
	output zx_display_pkg::igrb_t pix_igrb,
	output logic pix_border
);
	import zx_display_pkg::*;

	logic lit;
	igrb_t igrb_next;

	// A set glyph bit is dark ink on a normal screen
	assign lit = ~(pixels.pix_bit ^ pixels.inverse ^ invert_video);

	// First matching rule wins
	always_comb begin
		if (pixels.border && black_border) begin
			igrb_next = '0;
		end else if (!chroma_en) begin
			igrb_next = {4{lit}};
		end else if (pixels.border) begin
			igrb_next = chroma_border;
		end else if (lit) begin
			igrb_next = pixels.attr[7:4];
		end else begin
			igrb_next = pixels.attr[3:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pix_valid <= 1'b0;
		end else begin
			pix_valid <= pixels.pix_en;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (pixels.pix_en) begin
			pix_igrb <= igrb_next;
			pix_border <= pixels.border;
		end
	end

endmodule

// File: source/display_if.sv
`timescale 1ns/1ns

// ==============================
// Cells from the fetch stage
// ==============================

interface cell_if;
	import zx_display_pkg::*;

	logic valid;
	char_code_t code;
	glyph_bits_t glyph;
	chroma_attr_t attr;
	// One pulse per cell taken out of the shifter buffer
	logic credit;

	modport fetch_side (
		output valid, code, glyph, attr,
		input credit
	);

	modport shift_side (
		input valid, code, glyph, attr,
		output credit
	);
endinterface

// ==============================
// Pixels from the shifter
// ==============================

interface pixel_if;
	import zx_display_pkg::*;

	logic pix_en;
	logic pix_bit;
	logic inverse;
	chroma_attr_t attr;
	logic border;

	modport shift_side (
		output pix_en, pix_bit, inverse, attr, border
	);

	modport mix_side (
		input pix_en, pix_bit, inverse, attr, border
	);
endinterface

// File: source/glyph_fetch.sv
`timescale 1ns/1ns
`include "zx_display_params.svh"

module glyph_fetch (
	input logic clk_sys,
	input logic reset,
	input logic font_wr,
	input zx_display_pkg::font_addr_t font_addr,
	input zx_display_pkg::glyph_bits_t font_data,
	input logic cell_valid,
	input zx_display_pkg::char_code_t cell_code,
	input zx_display_pkg::glyph_row_t cell_row,
	input zx_display_pkg::chroma_attr_t cell_attr,
	output logic cell_credit,
	cell_if.fetch_side cells
);
	import zx_display_pkg::*;

	glyph_bits_t font_ram [`ZX_FONT_DEPTH];
	font_addr_t rd_addr;

	// Bit 6 of the code plays no part in the lookup
	assign rd_addr = {cell_code[5:0], cell_row};

	// Font load port
	always_ff @(posedge clk_sys) begin
		if (font_wr) begin
			font_ram[font_addr] <= font_data;
		end
	end

	// Glyph row read, code and attribute kept alongside
	always_ff @(posedge clk_sys) begin
		if (cell_valid) begin
			cells.glyph <= font_ram[rd_addr];
			cells.code <= cell_code;
			cells.attr <= cell_attr;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cells.valid <= 1'b0;
		end else begin
			cells.valid <= cell_valid;
		end
	end

	// Credits go straight back to the source
	assign cell_credit = cells.credit;

endmodule

// File: source/pixel_shifter.sv
`timescale 1ns/1ns
`include "zx_display_params.svh"

module pixel_shifter (
	input logic clk_sys,
	input logic reset,
	cell_if.shift_side cells,
	pixel_if.shift_side pixels
);
	import zx_display_pkg::*;

	localparam int DIV_W = $clog2(`ZX_PIXEL_DIV);
	localparam int BUF_DEPTH = `ZX_CELL_CREDITS;
	localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
	localparam int CNT_W = $clog2(BUF_DEPTH + 1);
	localparam int GLYPH_W = $bits(glyph_bits_t);
	localparam int BIT_W = $clog2(GLYPH_W);

	logic [DIV_W-1:0] div_cnt;
	logic pix_en;

	logic buf_inv [BUF_DEPTH];
	glyph_bits_t buf_glyph [BUF_DEPTH];
	chroma_attr_t buf_attr [BUF_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] buf_cnt;
	logic buf_empty;

	shift_state_t state;
	logic [BIT_W-1:0] bit_cnt;
	glyph_bits_t shift_reg;
	logic cur_inv;
	chroma_attr_t cur_attr;
	logic in_glyph;
	logic cell_done;
	logic load;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(BUF_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// ==============================
	// Pixel enable
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt <= '0;
		end else if (pix_en) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign pix_en = (div_cnt == DIV_W'(`ZX_PIXEL_DIV - 1));

	// ==============================
	// Cell buffer
	// ==============================

	// Only the inverse flag of the code matters from here on
	always_ff @(posedge clk_sys) begin
		if (cells.valid) begin
			buf_inv[wr_ptr] <= cells.code[7];
			buf_glyph[wr_ptr] <= cells.glyph;
			buf_attr[wr_ptr] <= cells.attr;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			buf_cnt <= '0;
		end else begin
			if (cells.valid) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (load) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			buf_cnt <= buf_cnt + CNT_W'(cells.valid) - CNT_W'(load);
		end
	end

	assign buf_empty = (buf_cnt == '0);

	// ==============================
	// Glyph shifter
	// ==============================

	assign in_glyph = (state == st_glyph);
	assign cell_done = pix_en && in_glyph && (bit_cnt == '1);

	// Back-to-back cells reload on the last pixel, no border gap
	assign load = !buf_empty && (!in_glyph || cell_done);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= st_border;
			bit_cnt <= '0;
		end else if (load) begin
			state <= st_glyph;
			bit_cnt <= '0;
		end else if (cell_done) begin
			state <= st_border;
		end else if (pix_en && in_glyph) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (load) begin
			shift_reg <= buf_glyph[rd_ptr];
			cur_inv <= buf_inv[rd_ptr];
			cur_attr <= buf_attr[rd_ptr];
		end else if (pix_en) begin
			shift_reg <= {shift_reg[GLYPH_W-2:0], 1'b0};
		end
	end

	assign cells.credit = load;

	// Border pixels go out as bit 0, not inverted
	assign pixels.pix_en = pix_en;
	assign pixels.pix_bit = in_glyph & shift_reg[GLYPH_W-1];
	assign pixels.inverse = in_glyph & cur_inv;
	assign pixels.attr = cur_attr;
	assign pixels.border = !in_glyph;

endmodule

// File: source/zx_display.sv
`timescale 1ns/1ns

module zx_display (
	input logic clk_sys,
	input logic reset,

	// Font load
	input logic font_wr,
	input zx_display_pkg::font_addr_t font_addr,
	input zx_display_pkg::glyph_bits_t font_data,

	// Cell stream with credit return
	input logic cell_valid,
	input zx_display_pkg::char_code_t cell_code,
	input zx_display_pkg::glyph_row_t cell_row,
	input zx_display_pkg::chroma_attr_t cell_attr,
	output logic cell_credit,

	// Display options
	input logic invert_video,
	input logic black_border,
	input logic chroma_en,
	input zx_display_pkg::igrb_t chroma_border,

	// Pixel output
	output logic pix_valid,
	output zx_display_pkg::igrb_t pix_igrb,
	output logic pix_border
);

	cell_if cell_bus ();
	pixel_if pixel_bus ();

	glyph_fetch u_glyph_fetch (
		.clk_sys(clk_sys),
		.reset(reset),
		.font_wr(font_wr),
		.font_addr(font_addr),
		.font_data(font_data),
		.cell_valid(cell_valid),
		.cell_code(cell_code),
		.cell_row(cell_row),
		.cell_attr(cell_attr),
		.cell_credit(cell_credit),
		.cells(cell_bus.fetch_side)
	);

	pixel_shifter u_pixel_shifter (
		.clk_sys(clk_sys),
		.reset(reset),
		.cells(cell_bus.shift_side),
		.pixels(pixel_bus.shift_side)
	);

	color_mixer u_color_mixer (
		.clk_sys(clk_sys),
		.reset(reset),
		.invert_video(invert_video),
		.black_border(black_border),
		.chroma_en(chroma_en),
		.chroma_border(chroma_border),
		.pixels(pixel_bus.mix_side),
		.pix_valid(pix_valid),
		.pix_igrb(pix_igrb),
		.pix_border(pix_border)
	);

endmodule

// File: source/zx_display_params.svh
`ifndef ZX_DISPLAY_PARAMS_SVH
`define ZX_DISPLAY_PARAMS_SVH

// Cells the source may have in flight, equal to the shifter buffer depth
`define ZX_CELL_CREDITS 2

// clk_sys cycles per pixel, as the 6.5 MHz enable of the original machine
`define ZX_PIXEL_DIV 8

// Rows in one glyph
`define ZX_GLYPH_ROWS 8

// Font RAM size in bytes, 64 glyphs of 8 rows
`define ZX_FONT_DEPTH 512

`endif

// File: source/zx_display_pkg.sv
package zx_display_pkg;

`include "zx_display_params.svh"

	// Bit 7 inverse, bits 5..0 glyph index
	typedef logic [7:0] char_code_t;

	typedef logic [$clog2(`ZX_GLYPH_ROWS)-1:0] glyph_row_t;

	// Glyph index above the row
	typedef logic [$clog2(`ZX_FONT_DEPTH)-1:0] font_addr_t;

	// Leftmost pixel in bit 7
	typedef logic [7:0] glyph_bits_t;

	// Upper nibble for lit pixels, lower nibble for dark ones
	typedef logic [7:0] chroma_attr_t;

	// Intensity, green, red, blue
	typedef logic [3:0] igrb_t;

	typedef enum logic {
		st_border,
		st_glyph
	} shift_state_t;

endpackage

// File: test/tb_zx_display.sv
`timescale 1ns/1ns
`include "zx_display_params.svh"

module tb_zx_display;
	import zx_display_pkg::*;

	logic clk_sys = 1'b0;
	logic reset;
	logic font_wr;
	font_addr_t font_addr;
	glyph_bits_t font_data;
	logic cell_valid;
	char_code_t cell_code;
	glyph_row_t cell_row;
	chroma_attr_t cell_attr;
	logic cell_credit;
	logic invert_video;
	logic black_border;
	logic chroma_en;
	igrb_t chroma_border;
	logic pix_valid;
	igrb_t pix_igrb;
	logic pix_border;

	glyph_bits_t font_model [`ZX_FONT_DEPTH];
	igrb_t exp_q [$];
	// Options as seen by the colour stage one cycle earlier
	logic [6:0] cfg_q;
	int cells_sent;
	int credits_back;
	int border_seen;
	int errors;
	int cycles;
	int cycle_limit;
	int seed_val;

	// Options per test are {invert_video, black_border, chroma_en, random inverse codes}
	string t_name [5] = '{"plain", "inverse", "chroma81", "border black", "border invert"};
	int t_cells [5] = '{40, 40, 40, 32, 32};
	int t_burst [5] = '{40, 40, 8, 4, 4};
	int t_gap [5] = '{0, 0, 40, 40, 40};
	logic [3:0] t_opts [5] = '{4'b0000, 4'b1001, 4'b0010, 4'b0100, 4'b1000};

	zx_display u_zx_display (.*);

	always #10 clk_sys = ~clk_sys;

	task automatic check_igrb(input string name, input igrb_t got, input igrb_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_logic(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	// Lit pixel is a clear glyph bit, flipped by either inverse source
	function automatic igrb_t glyph_colour(input logic pix, input logic inv, input chroma_attr_t attr);
		logic lit;
		lit = !(pix ^ inv ^ invert_video);
		if (chroma_en) begin
			return lit ? attr[7:4] : attr[3:0];
		end
		return lit ? 4'hf : 4'h0;
	endfunction

	function automatic igrb_t border_colour(input logic [6:0] cfg);
		if (cfg[5]) begin
			return '0;
		end
		if (cfg[4]) begin
			return cfg[3:0];
		end
		return {4{!cfg[6]}};
	endfunction

	// ==============================
	// Output monitor
	// ==============================

	always @(posedge clk_sys) begin
		if (!reset) begin
			if (cell_credit) begin
				if (credits_back >= cells_sent) begin
					errors++;
					$display("Credit returned with no cell outstanding");
				end
				credits_back++;
			end
			if (pix_valid && pix_border) begin
				border_seen++;
				check_igrb("pix_igrb border", pix_igrb, border_colour(cfg_q));
			end else if (pix_valid && exp_q.size() == 0) begin
				errors++;
				$display("Glyph pixel arrived with no cell expected");
			end else if (pix_valid) begin
				check_igrb("pix_igrb", pix_igrb, exp_q.pop_front());
			end
		end
		cfg_q <= {invert_video, black_border, chroma_en, chroma_border};
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, the pipeline did not drain", cycles);
			$display("sim failed");
			$finish;
		end
	end

	// ==============================
	// Stimulus
	// ==============================

	task automatic send_cell(input logic rand_inv);
		char_code_t code;
		glyph_row_t row;
		chroma_attr_t attr;
		glyph_bits_t glyph;
		code = char_code_t'($urandom);
		row = glyph_row_t'($urandom_range(`ZX_GLYPH_ROWS - 1));
		attr = chroma_attr_t'($urandom);
		if (!rand_inv) begin
			code[7] = 1'b0;
		end
		// No ready signal, the source stalls on its own credit count
		while (cells_sent - credits_back >= `ZX_CELL_CREDITS) begin
			@(posedge clk_sys);
			#1;
		end
		glyph = font_model[{code[5:0], row}];
		for (int i = 0; i < 8; i++) begin
			exp_q.push_back(glyph_colour(glyph[7], code[7], attr));
			glyph = glyph << 1;
		end
		cell_valid = 1'b1;
		cell_code = code;
		cell_row = row;
		cell_attr = attr;
		cells_sent++;
		@(posedge clk_sys);
		#1;
		cell_valid = 1'b0;
	endtask

	// Every expected pixel has come out
	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(posedge clk_sys);
			#1;
		end
	endtask

	task automatic run_test(input logic [2:0] t);
		int errors_before;
		errors_before = errors;
		invert_video = t_opts[t][3];
		black_border = t_opts[t][2];
		chroma_en = t_opts[t][1];
		chroma_border = igrb_t'($urandom);
		border_seen = 0;
		for (int c = 0; c < t_cells[t]; c++) begin
			send_cell(t_opts[t][0]);
			if ((c + 1) % t_burst[t] == 0) begin
				wait_drain();
				repeat (t_gap[t]) begin
					@(posedge clk_sys);
					#1;
				end
			end
		end
		check_logic("cell_credit total matches cells", credits_back == cells_sent, 1'b1);
		if (t_gap[t] > 0 && border_seen == 0) begin
			errors++;
			$display("No border pixels came out between bursts");
		end
		$display("Test %s done: %0d cells, %0d border pixels, %0d errors",
			t_name[t], t_cells[t], border_seen, errors - errors_before);
	endtask

	initial begin
		seed_val = $urandom(86988);
		cycle_limit = 0;
		for (logic [2:0] t = 0; t < 3'd5; t++) begin
			cycle_limit += t_cells[t] * `ZX_PIXEL_DIV * 8 + (t_cells[t] / t_burst[t]) * t_gap[t];
		end
		cycle_limit = cycle_limit * 2;
		errors = 0;
		cycles = 0;
		cells_sent = 0;
		credits_back = 0;
		border_seen = 0;
		reset = 1'b1;
		font_wr = 1'b0;
		font_addr = '0;
		font_data = '0;
		cell_valid = 1'b0;
		cell_code = '0;
		cell_row = '0;
		cell_attr = '0;
		invert_video = 1'b0;
		black_border = 1'b0;
		chroma_en = 1'b0;
		chroma_border = '0;
		repeat (16) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		// Font load, one random byte per cycle
		font_wr = 1'b1;
		for (int a = 0; a < `ZX_FONT_DEPTH; a++) begin
			font_addr = font_addr_t'(a);
			font_data = glyph_bits_t'($urandom);
			font_model[font_addr] = font_data;
			@(posedge clk_sys);
			#1;
		end
		font_wr = 1'b0;

		for (logic [2:0] t = 0; t < 3'd5; t++) begin
			run_test(t);
		end

		$display("Cells sent %0d, credits returned %0d, errors %0d",
			cells_sent, credits_back, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
